// ==== filelist.f ====
+incdir+bench
design/pd_pkg.sv
design/pd_slot_decoder.sv
design/predecode_lanes.sv
design/stream_capture.sv
design/redirect_check.sv
design/predecode_top.sv
bench/tb_predecode.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the predecode testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_predecode -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_predecode > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -qF "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation PASSED"
exit 0

// ==== bench/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: inst0, inst1, inst2, inst3, slot enables, start address, fsq index,
// predicted taken, predicted tail slot, predicted target.
typedef struct packed {
    pd_pkg::inst_t      inst0;
    pd_pkg::inst_t      inst1;
    pd_pkg::inst_t      inst2;
    pd_pkg::inst_t      inst3;
    pd_pkg::slot_mask_t en;
    pd_pkg::vaddr_t     start_addr;
    pd_pkg::fsq_idx_t   fsq_idx;
    logic               taken;
    pd_pkg::slot_idx_t  tail;
    pd_pkg::vaddr_t     target;
} vec_row_t;

localparam pd_pkg::inst_t alu       = 32'h0000_0013;  // addi, operand bits filled at random.
localparam pd_pkg::inst_t beq8      = 32'h0000_0463;  // beq x0, x0, +8.
localparam pd_pkg::inst_t jal16     = 32'h0100_006f;  // jal x0, +16.
localparam pd_pkg::inst_t jal_m8    = 32'hff9f_f06f;  // jal x0, -8.
localparam pd_pkg::inst_t jalr_call = 32'h0005_00e7;  // jalr x1, 0(x10).
localparam pd_pkg::inst_t jalr_t0   = 32'h0002_8067;  // jalr x0, 0(x5).
localparam pd_pkg::inst_t jalr_x6   = 32'h0003_0067;  // jalr x0, 0(x6).

localparam int num_rows = 23;

localparam vec_row_t vectors [num_rows] = '{
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_1000, 4'h1, 1'b0, 2'd0, 32'h0},
    '{alu, beq8, alu, alu, 4'b1111, 32'h0000_1010, 4'h2, 1'b0, 2'd0, 32'h0},
    '{alu, alu, jal16, alu, 4'b1111, 32'h0000_1020, 4'h3, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_1030, 4'h4, 1'b0, 2'd0, 32'h0},
    '{alu, jal16, alu, alu, 4'b0011, 32'h0000_1040, 4'h5, 1'b1, 2'd1, 32'h0000_1058},
    '{jal16, alu, alu, alu, 4'b1111, 32'h0000_1050, 4'h6, 1'b0, 2'd0, 32'h0},
    '{alu, jal16, alu, alu, 4'b0011, 32'h0000_1040, 4'h7, 1'b1, 2'd1, 32'h0000_1054},
    '{alu, jal_m8, alu, alu, 4'b1111, 32'h0000_2000, 4'h8, 1'b1, 2'd2, 32'h0000_1ffc},
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_2010, 4'h9, 1'b0, 2'd0, 32'h0},
    '{beq8, alu, alu, alu, 4'b1111, 32'h0000_2020, 4'ha, 1'b1, 2'd3, 32'h0000_2030},
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_2030, 4'hb, 1'b0, 2'd0, 32'h0},
    '{alu, jalr_call, alu, alu, 4'b1111, 32'h0000_3000, 4'hc, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_3010, 4'hd, 1'b0, 2'd0, 32'h0},
    '{jalr_t0, alu, alu, alu, 4'b1111, 32'h0000_3020, 4'he, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_3030, 4'hf, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, jalr_x6, 4'b1111, 32'h0000_3040, 4'h0, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, alu, 4'b1111, 32'h0000_3050, 4'h1, 1'b0, 2'd0, 32'h0},
    '{alu, alu, jalr_x6, alu, 4'b0111, 32'h0000_4000, 4'h2, 1'b1, 2'd2, 32'h0},
    '{alu, alu, alu, alu, 4'b0101, 32'h0000_4010, 4'h3, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, alu, 4'b0000, 32'h0000_4020, 4'h4, 1'b0, 2'd0, 32'h0},
    '{alu, alu, jal16, alu, 4'b0011, 32'h0000_4030, 4'h5, 1'b0, 2'd0, 32'h0},
    '{alu, alu, alu, jal_m8, 4'b1111, 32'h0000_4040, 4'h6, 1'b1, 2'd3, 32'h0000_4044},
    '{alu, alu, alu, alu, 4'b1000, 32'h0000_4050, 4'h7, 1'b0, 2'd0, 32'h0}
};

`endif

// ==== bench/tb_predecode.sv ====
`timescale 1ns/1ps

module tb_predecode;

    `include "tb_vectors.svh"

    localparam int timeout_cycles = num_rows + 20;

    logic               clk = 1'b0;
    logic               rst_n;
    pd_pkg::slot_mask_t fetch_en;
    pd_pkg::inst_t      fetch_inst0;
    pd_pkg::inst_t      fetch_inst1;
    pd_pkg::inst_t      fetch_inst2;
    pd_pkg::inst_t      fetch_inst3;
    pd_pkg::vaddr_t     fetch_start_addr;
    pd_pkg::fsq_idx_t   fetch_fsq_idx;
    logic               pred_taken;
    pd_pkg::slot_idx_t  pred_tail;
    pd_pkg::vaddr_t     pred_target;
    logic               redirect;
    pd_pkg::fsq_idx_t   redirect_fsq_idx;
    pd_pkg::vaddr_t     redirect_pc;
    pd_pkg::slot_idx_t  redirect_offset;
    pd_pkg::br_type_t   redirect_br_type;
    pd_pkg::ras_type_t  redirect_ras_type;
    pd_pkg::slot_mask_t ibuf_en;
    pd_pkg::inst_num_t  ibuf_num;
    pd_pkg::inst_t      ibuf_inst0;
    pd_pkg::inst_t      ibuf_inst1;
    pd_pkg::inst_t      ibuf_inst2;
    pd_pkg::inst_t      ibuf_inst3;

    vec_row_t pending;  // row on the inputs, taken at the next edge.
    vec_row_t staged;   // row the DUT should now hold in its stage.
    int       cycle_count;

    predecode_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .fetch_en(fetch_en),
        .fetch_inst0(fetch_inst0), .fetch_inst1(fetch_inst1),
        .fetch_inst2(fetch_inst2), .fetch_inst3(fetch_inst3),
        .fetch_start_addr(fetch_start_addr), .fetch_fsq_idx(fetch_fsq_idx),
        .pred_taken(pred_taken), .pred_tail(pred_tail), .pred_target(pred_target),
        .redirect(redirect), .redirect_fsq_idx(redirect_fsq_idx),
        .redirect_pc(redirect_pc), .redirect_offset(redirect_offset),
        .redirect_br_type(redirect_br_type), .redirect_ras_type(redirect_ras_type),
        .ibuf_en(ibuf_en), .ibuf_num(ibuf_num),
        .ibuf_inst0(ibuf_inst0), .ibuf_inst1(ibuf_inst1),
        .ibuf_inst2(ibuf_inst2), .ibuf_inst3(ibuf_inst3)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("Run timed out after %0d cycles before the table was done", cycle_count);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    function automatic pd_pkg::inst_t inst_of(vec_row_t r, int i);
        case (i)
            0:       return r.inst0;
            1:       return r.inst1;
            2:       return r.inst2;
            default: return r.inst3;
        endcase
    endfunction

    function automatic logic [6:0] opcode_of(pd_pkg::inst_t inst);
        return inst[6:0];
    endfunction

    function automatic logic [4:0] rd_of(pd_pkg::inst_t inst);
        return inst[11:7];
    endfunction

    function automatic logic [4:0] rs1_of(pd_pkg::inst_t inst);
        return inst[19:15];
    endfunction

    function automatic logic is_link(logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    function automatic logic is_jump(pd_pkg::inst_t inst);
        return (opcode_of(inst) == 7'h6f) || (opcode_of(inst) == 7'h67);
    endfunction

    function automatic pd_pkg::vaddr_t jal_target(pd_pkg::inst_t inst, pd_pkg::vaddr_t addr);
        logic [20:0] imm;
        imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return addr + {{11{imm[20]}}, imm};
    endfunction

    function automatic pd_pkg::br_type_t br_type_of(pd_pkg::inst_t inst);
        if (opcode_of(inst) == 7'h6f) begin
            return pd_pkg::br_direct;
        end
        if (opcode_of(inst) == 7'h67) begin
            return (is_link(rd_of(inst)) || is_link(rs1_of(inst))) ? pd_pkg::br_call
                                                                    : pd_pkg::br_indirect;
        end
        return pd_pkg::br_condition;
    endfunction

    function automatic pd_pkg::ras_type_t ras_type_of(pd_pkg::inst_t inst);
        case ({is_link(rd_of(inst)), is_link(rs1_of(inst))})
            2'b01:   return pd_pkg::ras_pop;
            2'b10:   return pd_pkg::ras_push;
            2'b11:   return pd_pkg::ras_pop_push;
            default: return pd_pkg::ras_none;
        endcase
    endfunction

    // lowest enabled jal or jalr, slot 0 when the block has none.
    function automatic pd_pkg::slot_idx_t lowest_jump(vec_row_t r);
        for (int i = 0; i < pd_pkg::block_insts; i++) begin
            if (r.en[i] && is_jump(inst_of(r, i))) begin
                return pd_pkg::slot_idx_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic logic has_jump(vec_row_t r);
        logic found;
        found = 1'b0;
        for (int i = 0; i < pd_pkg::block_insts; i++) begin
            found = found | (r.en[i] & is_jump(inst_of(r, i)));
        end
        return found;
    endfunction

    function automatic logic expect_redirect(vec_row_t r);
        pd_pkg::inst_t  tail_inst;
        pd_pkg::vaddr_t tail_addr;
        tail_inst = inst_of(r, int'(r.tail));
        tail_addr = r.start_addr + (pd_pkg::vaddr_t'(r.tail) << 2);
        if (!r.taken) begin
            return has_jump(r);
        end
        if (!has_jump(r) || (lowest_jump(r) != r.tail)) begin
            return 1'b1;
        end
        return (opcode_of(tail_inst) == 7'h6f) && (jal_target(tail_inst, tail_addr) != r.target);
    endfunction

    function automatic pd_pkg::inst_t fill_operands(pd_pkg::inst_t inst);
        logic [31:0] rnd;
        rnd = $urandom;
        if (opcode_of(inst) == 7'h13) begin
            return {rnd[31:7], inst[6:0]};
        end
        return inst;
    endfunction

    function automatic vec_row_t with_random_fill(vec_row_t r);
        vec_row_t filled;
        filled       = r;
        filled.inst0 = fill_operands(r.inst0);
        filled.inst1 = fill_operands(r.inst1);
        filled.inst2 = fill_operands(r.inst2);
        filled.inst3 = fill_operands(r.inst3);
        return filled;
    endfunction

    task automatic drive_row(vec_row_t r);
        fetch_en         <= r.en;
        fetch_inst0      <= r.inst0;
        fetch_inst1      <= r.inst1;
        fetch_inst2      <= r.inst2;
        fetch_inst3      <= r.inst3;
        fetch_start_addr <= r.start_addr;
        fetch_fsq_idx    <= r.fsq_idx;
        pred_taken       <= r.taken;
        pred_tail        <= r.tail;
        pred_target      <= r.target;
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_redirect(logic exp_redirect, pd_pkg::fsq_idx_t exp_fsq,
                                  pd_pkg::vaddr_t exp_pc, pd_pkg::slot_idx_t exp_offset,
                                  pd_pkg::br_type_t exp_br, pd_pkg::ras_type_t exp_ras);
        if (redirect !== exp_redirect) begin
            report_mismatch("redirect", 32'(exp_redirect), 32'(redirect));
        end
        if (exp_redirect) begin  // the fields only mean something with redirect high.
            if (redirect_fsq_idx !== exp_fsq) begin
                report_mismatch("redirect_fsq_idx", 32'(exp_fsq), 32'(redirect_fsq_idx));
            end
            if (redirect_pc !== exp_pc) begin
                report_mismatch("redirect_pc", exp_pc, redirect_pc);
            end
            if (redirect_offset !== exp_offset) begin
                report_mismatch("redirect_offset", 32'(exp_offset), 32'(redirect_offset));
            end
            if (redirect_br_type !== exp_br) begin
                report_mismatch("redirect_br_type", 32'(exp_br), 32'(redirect_br_type));
            end
            if (redirect_ras_type !== exp_ras) begin
                report_mismatch("redirect_ras_type", 32'(exp_ras), 32'(redirect_ras_type));
            end
        end
    endtask

    task automatic check_ibuf(pd_pkg::slot_mask_t exp_en, pd_pkg::inst_num_t exp_num,
                              pd_pkg::inst_t exp_inst0, pd_pkg::inst_t exp_inst1,
                              pd_pkg::inst_t exp_inst2, pd_pkg::inst_t exp_inst3);
        pd_pkg::inst_t exp_inst [pd_pkg::block_insts];
        pd_pkg::inst_t act_inst [pd_pkg::block_insts];
        exp_inst = '{exp_inst0, exp_inst1, exp_inst2, exp_inst3};
        act_inst = '{ibuf_inst0, ibuf_inst1, ibuf_inst2, ibuf_inst3};
        if (ibuf_en !== exp_en) begin
            report_mismatch("ibuf_en", 32'(exp_en), 32'(ibuf_en));
        end
        if (ibuf_num !== exp_num) begin
            report_mismatch("ibuf_num", 32'(exp_num), 32'(ibuf_num));
        end
        for (int i = 0; i < pd_pkg::block_insts; i++) begin
            if (exp_en[i] && (act_inst[i] !== exp_inst[i])) begin
                report_mismatch($sformatf("ibuf_inst%0d", i), exp_inst[i], act_inst[i]);
            end
        end
    endtask

    task automatic check_outputs(vec_row_t r);
        logic               redir;
        pd_pkg::slot_idx_t  slot;
        pd_pkg::br_type_t   br;
        pd_pkg::ras_type_t  ras;
        pd_pkg::slot_mask_t en;
        pd_pkg::inst_num_t  num;
        redir = expect_redirect(r);
        slot  = lowest_jump(r);
        br    = r.en[slot] ? br_type_of(inst_of(r, int'(slot))) : pd_pkg::br_condition;
        ras   = r.en[slot] ? ras_type_of(inst_of(r, int'(slot))) : pd_pkg::ras_none;
        en    = redir ? '0 : r.en;
        num   = redir ? '0 : pd_pkg::inst_num_t'($countones(r.en));
        check_redirect(redir, r.fsq_idx, r.start_addr, slot, br, ras);
        check_ibuf(en, num, r.inst0, r.inst1, r.inst2, r.inst3);
    endtask

    initial begin
        logic [31:0] seed_out;
        vec_row_t    row;
        seed_out    = $urandom(32'hb19d_d741);
        cycle_count = 0;
        pending     = '0;
        staged      = '0;
        rst_n <= 1'b0;
        drive_row('0);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs(staged);
        // two extra empty rows drain the stage at the end.
        for (int c = 0; c < num_rows + 2; c++) begin
            @(posedge clk);
            if (expect_redirect(staged)) begin
                staged = '0;  // the stage is flushed and the pending row is lost.
            end else begin
                staged = pending;
            end
            row = (c < num_rows) ? with_random_fill(vectors[c]) : '0;
            drive_row(row);
            pending = row;
            @(negedge clk);
            check_outputs(staged);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== design/predecode_top.sv ====
`timescale 1ns/1ps

module predecode_top (
    input  logic                clk,
    input  logic                rst_n,
    input  pd_pkg::slot_mask_t  fetch_en,
    input  pd_pkg::inst_t       fetch_inst0,
    input  pd_pkg::inst_t       fetch_inst1,
    input  pd_pkg::inst_t       fetch_inst2,
    input  pd_pkg::inst_t       fetch_inst3,
    input  pd_pkg::vaddr_t      fetch_start_addr,
    input  pd_pkg::fsq_idx_t    fetch_fsq_idx,
    input  logic                pred_taken,
    input  pd_pkg::slot_idx_t   pred_tail,
    input  pd_pkg::vaddr_t      pred_target,
    output logic                redirect,
    output pd_pkg::fsq_idx_t    redirect_fsq_idx,
    output pd_pkg::vaddr_t      redirect_pc,
    output pd_pkg::slot_idx_t   redirect_offset,
    output pd_pkg::br_type_t    redirect_br_type,
    output pd_pkg::ras_type_t   redirect_ras_type,
    output pd_pkg::slot_mask_t  ibuf_en,
    output pd_pkg::inst_num_t   ibuf_num,
    output pd_pkg::inst_t       ibuf_inst0,
    output pd_pkg::inst_t       ibuf_inst1,
    output pd_pkg::inst_t       ibuf_inst2,
    output pd_pkg::inst_t       ibuf_inst3
);

    pd_pkg::slot_mask_t jump_mask;
    pd_pkg::slot_mask_t jal_mask;
    pd_pkg::vaddr_t     slot_target0, slot_target1, slot_target2, slot_target3;
    pd_pkg::br_type_t   slot_br_type0, slot_br_type1, slot_br_type2, slot_br_type3;
    pd_pkg::ras_type_t  slot_ras_type0, slot_ras_type1, slot_ras_type2, slot_ras_type3;
    pd_pkg::slot_mask_t stage_en;
    pd_pkg::inst_t      stage_inst0, stage_inst1, stage_inst2, stage_inst3;
    pd_pkg::fsq_idx_t   stage_fsq_idx;
    pd_pkg::vaddr_t     stage_start_addr;
    logic               stage_taken;
    pd_pkg::slot_idx_t  stage_tail;
    pd_pkg::vaddr_t     stage_target;
    pd_pkg::inst_num_t  stage_num;

    // redirect flushes both halves of the stage on the next edge.
    predecode_lanes i_lanes (
        .clk(clk), .rst_n(rst_n), .flush(redirect),
        .fetch_en(fetch_en),
        .fetch_inst0(fetch_inst0), .fetch_inst1(fetch_inst1),
        .fetch_inst2(fetch_inst2), .fetch_inst3(fetch_inst3),
        .fetch_start_addr(fetch_start_addr),
        .jump_mask(jump_mask), .jal_mask(jal_mask),
        .slot_target0(slot_target0), .slot_target1(slot_target1),
        .slot_target2(slot_target2), .slot_target3(slot_target3),
        .slot_br_type0(slot_br_type0), .slot_br_type1(slot_br_type1),
        .slot_br_type2(slot_br_type2), .slot_br_type3(slot_br_type3),
        .slot_ras_type0(slot_ras_type0), .slot_ras_type1(slot_ras_type1),
        .slot_ras_type2(slot_ras_type2), .slot_ras_type3(slot_ras_type3)
    );

    stream_capture i_capture (
        .clk(clk), .rst_n(rst_n), .flush(redirect),
        .fetch_en(fetch_en),
        .fetch_inst0(fetch_inst0), .fetch_inst1(fetch_inst1),
        .fetch_inst2(fetch_inst2), .fetch_inst3(fetch_inst3),
        .fetch_fsq_idx(fetch_fsq_idx), .fetch_start_addr(fetch_start_addr),
        .pred_taken(pred_taken), .pred_tail(pred_tail), .pred_target(pred_target),
        .stage_en(stage_en),
        .stage_inst0(stage_inst0), .stage_inst1(stage_inst1),
        .stage_inst2(stage_inst2), .stage_inst3(stage_inst3),
        .stage_fsq_idx(stage_fsq_idx), .stage_start_addr(stage_start_addr),
        .stage_taken(stage_taken), .stage_tail(stage_tail), .stage_target(stage_target),
        .stage_num(stage_num)
    );

    redirect_check i_check (
        .jump_mask(jump_mask), .jal_mask(jal_mask),
        .slot_target0(slot_target0), .slot_target1(slot_target1),
        .slot_target2(slot_target2), .slot_target3(slot_target3),
        .slot_br_type0(slot_br_type0), .slot_br_type1(slot_br_type1),
        .slot_br_type2(slot_br_type2), .slot_br_type3(slot_br_type3),
        .slot_ras_type0(slot_ras_type0), .slot_ras_type1(slot_ras_type1),
        .slot_ras_type2(slot_ras_type2), .slot_ras_type3(slot_ras_type3),
        .stage_en(stage_en),
        .stage_inst0(stage_inst0), .stage_inst1(stage_inst1),
        .stage_inst2(stage_inst2), .stage_inst3(stage_inst3),
        .stage_fsq_idx(stage_fsq_idx), .stage_start_addr(stage_start_addr),
        .stage_taken(stage_taken), .stage_tail(stage_tail), .stage_target(stage_target),
        .stage_num(stage_num),
        .redirect(redirect), .redirect_fsq_idx(redirect_fsq_idx),
        .redirect_pc(redirect_pc), .redirect_offset(redirect_offset),
        .redirect_br_type(redirect_br_type), .redirect_ras_type(redirect_ras_type),
        .ibuf_en(ibuf_en), .ibuf_num(ibuf_num),
        .ibuf_inst0(ibuf_inst0), .ibuf_inst1(ibuf_inst1),
        .ibuf_inst2(ibuf_inst2), .ibuf_inst3(ibuf_inst3)
    );

endmodule

// ==== design/redirect_check.sv ====
`timescale 1ns/1ps

module redirect_check (
    input  pd_pkg::slot_mask_t  jump_mask,
    input  pd_pkg::slot_mask_t  jal_mask,
    input  pd_pkg::vaddr_t      slot_target0,
    input  pd_pkg::vaddr_t      slot_target1,
    input  pd_pkg::vaddr_t      slot_target2,
    input  pd_pkg::vaddr_t      slot_target3,
    input  pd_pkg::br_type_t    slot_br_type0,
    input  pd_pkg::br_type_t    slot_br_type1,
    input  pd_pkg::br_type_t    slot_br_type2,
    input  pd_pkg::br_type_t    slot_br_type3,
    input  pd_pkg::ras_type_t   slot_ras_type0,
    input  pd_pkg::ras_type_t   slot_ras_type1,
    input  pd_pkg::ras_type_t   slot_ras_type2,
    input  pd_pkg::ras_type_t   slot_ras_type3,
    input  pd_pkg::slot_mask_t  stage_en,
    input  pd_pkg::inst_t       stage_inst0,
    input  pd_pkg::inst_t       stage_inst1,
    input  pd_pkg::inst_t       stage_inst2,
    input  pd_pkg::inst_t       stage_inst3,
    input  pd_pkg::fsq_idx_t    stage_fsq_idx,
    input  pd_pkg::vaddr_t      stage_start_addr,
    input  logic                stage_taken,
    input  pd_pkg::slot_idx_t   stage_tail,
    input  pd_pkg::vaddr_t      stage_target,
    input  pd_pkg::inst_num_t   stage_num,
    output logic                redirect,
    output pd_pkg::fsq_idx_t    redirect_fsq_idx,
    output pd_pkg::vaddr_t      redirect_pc,
    output pd_pkg::slot_idx_t   redirect_offset,
    output pd_pkg::br_type_t    redirect_br_type,
    output pd_pkg::ras_type_t   redirect_ras_type,
    output pd_pkg::slot_mask_t  ibuf_en,
    output pd_pkg::inst_num_t   ibuf_num,
    output pd_pkg::inst_t       ibuf_inst0,
    output pd_pkg::inst_t       ibuf_inst1,
    output pd_pkg::inst_t       ibuf_inst2,
    output pd_pkg::inst_t       ibuf_inst3
);

    pd_pkg::vaddr_t    targets  [pd_pkg::block_insts];
    pd_pkg::br_type_t  br_types [pd_pkg::block_insts];
    pd_pkg::ras_type_t ras_types[pd_pkg::block_insts];
    pd_pkg::slot_idx_t first_jump;
    logic              any_jump;
    logic              target_miss;

    assign targets   = '{slot_target0, slot_target1, slot_target2, slot_target3};
    assign br_types  = '{slot_br_type0, slot_br_type1, slot_br_type2, slot_br_type3};
    assign ras_types = '{slot_ras_type0, slot_ras_type1, slot_ras_type2, slot_ras_type3};

    // lowest set bit wins, so scan from the top down.
    always_comb begin
        first_jump = '0;
        for (int i = pd_pkg::block_insts - 1; i >= 0; i--) begin
            if (jump_mask[i]) begin
                first_jump = pd_pkg::slot_idx_t'(i);
            end
        end
    end

    assign any_jump    = |jump_mask;
    assign target_miss = jal_mask[stage_tail] && (targets[stage_tail] != stage_target);

    always_comb begin
        if (stage_taken) begin
            redirect = !any_jump || (first_jump != stage_tail) || target_miss;
        end else begin
            redirect = any_jump;  // a jump the predictor did not see.
        end
    end

    assign redirect_fsq_idx  = stage_fsq_idx;
    assign redirect_pc       = stage_start_addr;
    assign redirect_offset   = first_jump;
    assign redirect_br_type  = br_types[first_jump];
    assign redirect_ras_type = ras_types[first_jump];

    // the block is dropped while fetch is being redirected.
    assign ibuf_en  = redirect ? '0 : stage_en;
    assign ibuf_num = redirect ? '0 : stage_num;

    assign ibuf_inst0 = stage_inst0;
    assign ibuf_inst1 = stage_inst1;
    assign ibuf_inst2 = stage_inst2;
    assign ibuf_inst3 = stage_inst3;

endmodule

// ==== design/stream_capture.sv ====
`timescale 1ns/1ps

module stream_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  pd_pkg::slot_mask_t  fetch_en,
    input  pd_pkg::inst_t       fetch_inst0,
    input  pd_pkg::inst_t       fetch_inst1,
    input  pd_pkg::inst_t       fetch_inst2,
    input  pd_pkg::inst_t       fetch_inst3,
    input  pd_pkg::fsq_idx_t    fetch_fsq_idx,
    input  pd_pkg::vaddr_t      fetch_start_addr,
    input  logic                pred_taken,
    input  pd_pkg::slot_idx_t   pred_tail,
    input  pd_pkg::vaddr_t      pred_target,
    output pd_pkg::slot_mask_t  stage_en,
    output pd_pkg::inst_t       stage_inst0,
    output pd_pkg::inst_t       stage_inst1,
    output pd_pkg::inst_t       stage_inst2,
    output pd_pkg::inst_t       stage_inst3,
    output pd_pkg::fsq_idx_t    stage_fsq_idx,
    output pd_pkg::vaddr_t      stage_start_addr,
    output logic                stage_taken,
    output pd_pkg::slot_idx_t   stage_tail,
    output pd_pkg::vaddr_t      stage_target,
    output pd_pkg::inst_num_t   stage_num
);

    pd_pkg::inst_num_t en_count;

    // population count of the slot enables.
    always_comb begin
        en_count = '0;
        for (int i = 0; i < pd_pkg::block_insts; i++) begin
            en_count = en_count + pd_pkg::inst_num_t'(fetch_en[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_en         <= '0;
            stage_inst0      <= '0;
            stage_inst1      <= '0;
            stage_inst2      <= '0;
            stage_inst3      <= '0;
            stage_fsq_idx    <= '0;
            stage_start_addr <= '0;
            stage_taken      <= 1'b0;
            stage_tail       <= '0;
            stage_target     <= '0;
            stage_num        <= '0;
        end else if (flush) begin
            stage_en         <= '0;
            stage_inst0      <= '0;
            stage_inst1      <= '0;
            stage_inst2      <= '0;
            stage_inst3      <= '0;
            stage_fsq_idx    <= '0;
            stage_start_addr <= '0;
            stage_taken      <= 1'b0;
            stage_tail       <= '0;
            stage_target     <= '0;
            stage_num        <= '0;
        end else begin
            stage_en         <= fetch_en;
            stage_inst0      <= fetch_inst0;
            stage_inst1      <= fetch_inst1;
            stage_inst2      <= fetch_inst2;
            stage_inst3      <= fetch_inst3;
            stage_fsq_idx    <= fetch_fsq_idx;
            stage_start_addr <= fetch_start_addr;
            stage_taken      <= pred_taken;
            stage_tail       <= pred_tail;
            stage_target     <= pred_target;
            stage_num        <= en_count;
        end
    end

endmodule

// ==== design/predecode_lanes.sv ====
`timescale 1ns/1ps

module predecode_lanes (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  pd_pkg::slot_mask_t fetch_en,
    input  pd_pkg::inst_t      fetch_inst0,
    input  pd_pkg::inst_t      fetch_inst1,
    input  pd_pkg::inst_t      fetch_inst2,
    input  pd_pkg::inst_t      fetch_inst3,
    input  pd_pkg::vaddr_t     fetch_start_addr,
    output pd_pkg::slot_mask_t jump_mask,
    output pd_pkg::slot_mask_t jal_mask,
    output pd_pkg::vaddr_t     slot_target0,
    output pd_pkg::vaddr_t     slot_target1,
    output pd_pkg::vaddr_t     slot_target2,
    output pd_pkg::vaddr_t     slot_target3,
    output pd_pkg::br_type_t   slot_br_type0,
    output pd_pkg::br_type_t   slot_br_type1,
    output pd_pkg::br_type_t   slot_br_type2,
    output pd_pkg::br_type_t   slot_br_type3,
    output pd_pkg::ras_type_t  slot_ras_type0,
    output pd_pkg::ras_type_t  slot_ras_type1,
    output pd_pkg::ras_type_t  slot_ras_type2,
    output pd_pkg::ras_type_t  slot_ras_type3
);

    pd_pkg::inst_t      insts      [pd_pkg::block_insts];
    pd_pkg::slot_mask_t dec_jal;
    pd_pkg::slot_mask_t dec_jalr;
    pd_pkg::slot_mask_t dec_branch;
    pd_pkg::vaddr_t     dec_target [pd_pkg::block_insts];
    pd_pkg::br_type_t   dec_br     [pd_pkg::block_insts];
    pd_pkg::ras_type_t  dec_ras    [pd_pkg::block_insts];
    pd_pkg::vaddr_t     target_q   [pd_pkg::block_insts];
    pd_pkg::br_type_t   br_q       [pd_pkg::block_insts];
    pd_pkg::ras_type_t  ras_q      [pd_pkg::block_insts];

    assign insts[0] = fetch_inst0;
    assign insts[1] = fetch_inst1;
    assign insts[2] = fetch_inst2;
    assign insts[3] = fetch_inst3;

    for (genvar i = 0; i < pd_pkg::block_insts; i++) begin : g_slot
        pd_slot_decoder i_dec (
            .inst      (insts[i]),
            .addr      (fetch_start_addr + (pd_pkg::vaddr_t'(i) << 2)),  // slot i sits at start + 4i.
            .is_jal    (dec_jal[i]),
            .is_jalr   (dec_jalr[i]),
            .is_branch (dec_branch[i]),
            .target    (dec_target[i]),
            .br_type   (dec_br[i]),
            .ras_type  (dec_ras[i])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_mask <= '0;
            jal_mask  <= '0;
            for (int i = 0; i < pd_pkg::block_insts; i++) begin
                target_q[i] <= '0;
                br_q[i]     <= pd_pkg::br_condition;
                ras_q[i]    <= pd_pkg::ras_none;
            end
        end else if (flush) begin
            jump_mask <= '0;
            jal_mask  <= '0;
            for (int i = 0; i < pd_pkg::block_insts; i++) begin
                target_q[i] <= '0;
                br_q[i]     <= pd_pkg::br_condition;
                ras_q[i]    <= pd_pkg::ras_none;
            end
        end else begin
            jump_mask <= fetch_en & (dec_jal | dec_jalr);
            jal_mask  <= fetch_en & dec_jal;
            for (int i = 0; i < pd_pkg::block_insts; i++) begin
                // only direct targets are kept, anything else reads as zero.
                target_q[i] <= (fetch_en[i] && (dec_jal[i] || dec_branch[i])) ? dec_target[i] : '0;
                br_q[i]     <= fetch_en[i] ? dec_br[i] : pd_pkg::br_condition;
                ras_q[i]    <= fetch_en[i] ? dec_ras[i] : pd_pkg::ras_none;
            end
        end
    end

    assign slot_target0   = target_q[0];
    assign slot_target1   = target_q[1];
    assign slot_target2   = target_q[2];
    assign slot_target3   = target_q[3];
    assign slot_br_type0  = br_q[0];
    assign slot_br_type1  = br_q[1];
    assign slot_br_type2  = br_q[2];
    assign slot_br_type3  = br_q[3];
    assign slot_ras_type0 = ras_q[0];
    assign slot_ras_type1 = ras_q[1];
    assign slot_ras_type2 = ras_q[2];
    assign slot_ras_type3 = ras_q[3];

endmodule

// ==== design/pd_slot_decoder.sv ====
`timescale 1ns/1ps

module pd_slot_decoder (
    input  pd_pkg::inst_t     inst,
    input  pd_pkg::vaddr_t    addr,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_branch,
    output pd_pkg::vaddr_t    target,
    output pd_pkg::br_type_t  br_type,
    output pd_pkg::ras_type_t ras_type
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       push;
    logic       pop;
    pd_pkg::vaddr_t j_imm;
    pd_pkg::vaddr_t b_imm;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];

    assign is_jal    = (opcode == pd_pkg::op_jal);
    assign is_jalr   = (opcode == pd_pkg::op_jalr);
    assign is_branch = (opcode == pd_pkg::op_branch);

    // sign-extended immediates, bit 0 is always zero.
    assign j_imm = {{(pd_pkg::vaddr_w-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};
    assign b_imm = {{(pd_pkg::vaddr_w-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};

    // jalr has no target here, its base register is not known yet.
    assign target = addr + (is_jal ? j_imm : b_imm);

    assign push = (rd == pd_pkg::reg_ra) || (rd == pd_pkg::reg_t0);
    assign pop  = (rs1 == pd_pkg::reg_ra) || (rs1 == pd_pkg::reg_t0);

    always_comb begin
        case ({push, pop})
            2'b01:   ras_type = pd_pkg::ras_pop;
            2'b10:   ras_type = pd_pkg::ras_push;
            2'b11:   ras_type = pd_pkg::ras_pop_push;
            default: ras_type = pd_pkg::ras_none;
        endcase
    end

    always_comb begin
        if (is_jal) begin
            br_type = pd_pkg::br_direct;
        end else if (is_jalr) begin
            // a jalr touching a link register is a call or a return.
            br_type = (push || pop) ? pd_pkg::br_call : pd_pkg::br_indirect;
        end else begin
            br_type = pd_pkg::br_condition;
        end
    end

endmodule

// ==== design/pd_pkg.sv ====
package pd_pkg;

    localparam int block_insts = 4;   // slots per fetch block.
    localparam int slot_w      = 2;
    localparam int num_w       = 3;   // one more bit than slot_w so a full block counts to 4.
    localparam int vaddr_w     = 32;
    localparam int fsq_w       = 4;

    // major opcodes of the control transfer instructions.
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // x1 (ra) and x5 (t0) are the link registers.
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

    typedef logic [31:0]          inst_t;
    typedef logic [vaddr_w-1:0]   vaddr_t;
    typedef logic [fsq_w-1:0]     fsq_idx_t;
    typedef logic [slot_w-1:0]    slot_idx_t;
    typedef logic [num_w-1:0]     inst_num_t;
    typedef logic [block_insts-1:0] slot_mask_t;

    typedef enum logic [1:0] {
        br_direct,
        br_indirect,
        br_call,
        br_condition
    } br_type_t;

    typedef enum logic [1:0] {
        ras_none,
        ras_pop,
        ras_push,
        ras_pop_push
    } ras_type_t;

endpackage
